//--- src/flash_boot_pkg.sv
`default_nettype none

package flash_boot_pkg;

  ////////////////////////////////////////////////////////////
  // SPI flash commands
  ////////////////////////////////////////////////////////////

  // Two-part software reset, enable then execute
  localparam logic [7:0] cmd_reset_enable = 8'h66;
  localparam logic [7:0] cmd_reset_memory = 8'h99;
  // Plain serial read, followed by a 24-bit address
  localparam logic [7:0] cmd_read         = 8'h03;

  // Outgoing shift width, large enough for a full flash address
  localparam int shift_out_w = 24;

  typedef logic [shift_out_w-1:0] flash_addr_t;

  // One boot word as written to ROM, or as its big-endian byte pair
  // First byte off the flash lands in hi
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
  } rom_word_u;

  // Request from sequencer to shift engine
  // out_data is left aligned, bit shift_out_w-1 goes out first
  typedef struct packed {
    logic                   start;
    logic [4:0]             out_bits;
    logic [shift_out_w-1:0] out_data;
    logic                   rx;
  } shift_req_t;

  // Response from shift engine, rx_byte valid while done is high
  typedef struct packed {
    logic       done;
    logic [7:0] rx_byte;
  } shift_rsp_t;

endpackage

`default_nettype wire

//--- src/flash_sck_gen.sv
`timescale 1ns/1ps
`default_nettype none

module flash_sck_gen #(
  parameter int clk_div = 8
) (
  input  wire  CLK,
  input  wire  rst_n,
  input  wire  sck_en,
  output logic sck,
  output logic sck_rise,
  output logic sck_fall
);

  // Divider counts 0 .. clk_div-1, one flash edge per wrap
  localparam int cnt_w = (clk_div > 1) ? $clog2(clk_div) : 1;
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clk_div - 1);

  logic [cnt_w-1:0] div_cnt;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      div_cnt  <= '0;
      sck      <= 1'b0;
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
    end else begin
      // Strobes last one cycle only
      sck_rise <= 1'b0;
      sck_fall <= 1'b0;
      if (!sck_en) begin
        // Idle, park SCK low and restart the divider
        div_cnt <= '0;
        sck     <= 1'b0;
      end else if (div_cnt == last_cnt) begin
        div_cnt  <= '0;
        sck      <= ~sck;
        // Old level tells which edge this is
        sck_rise <= ~sck;
        sck_fall <= sck;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/flash_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

module flash_shift_engine import flash_boot_pkg::*; (
  input  wire        CLK,
  input  wire        rst_n,
  input  wire        shift_req_t req,
  input  wire        sck_rise,
  input  wire        sck_fall,
  input  wire        flash_io1,
  output shift_rsp_t rsp,
  output logic       sck_en,
  output logic       flash_io0
);

  localparam logic [1:0] eng_idle = 2'd0;
  localparam logic [1:0] eng_tx   = 2'd1;
  localparam logic [1:0] eng_rx   = 2'd2;

  logic [1:0]             state;
  logic [4:0]             bit_cnt;
  logic [4:0]             out_len;
  logic                   rx_en;
  logic [2:0]             rx_cnt;
  logic                   done_q;
  logic [shift_out_w-1:0] out_sh;
  logic [7:0]             rx_sh;

  assign rsp = '{done: done_q, rx_byte: rx_sh};

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state     <= eng_idle;
      bit_cnt   <= '0;
      out_len   <= '0;
      rx_en     <= 1'b0;
      rx_cnt    <= '0;
      done_q    <= 1'b0;
      sck_en    <= 1'b0;
      flash_io0 <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        eng_idle: begin
          if (req.start) begin
            out_len <= req.out_bits;
            rx_en   <= req.rx;
            bit_cnt <= '0;
            rx_cnt  <= '0;
            sck_en  <= 1'b1;
            if (req.out_bits != 5'd0) begin
              // MSB sits on IO0 before the first rise
              flash_io0 <= req.out_data[shift_out_w-1];
              state     <= eng_tx;
            end else begin
              // Zero bits out means a receive-only byte
              flash_io0 <= 1'b0;
              state     <= eng_rx;
            end
          end
        end
        eng_tx: begin
          // Flash latches IO0 on the rise, next bit goes out on the fall
          if (sck_fall) begin
            flash_io0 <= out_sh[shift_out_w-2];
          end
          if (sck_rise) begin
            if (bit_cnt == out_len - 5'd1) begin
              flash_io0 <= 1'b0;
              if (rx_en) begin
                // SCK stays high, the following fall samples bit 7
                state <= eng_rx;
              end else begin
                sck_en <= 1'b0;
                done_q <= 1'b1;
                state  <= eng_idle;
              end
            end else begin
              bit_cnt <= bit_cnt + 5'd1;
            end
          end
        end
        eng_rx: begin
          // Eight falls per byte, SCK ends low
          if (sck_fall) begin
            if (rx_cnt == 3'd7) begin
              sck_en <= 1'b0;
              done_q <= 1'b1;
              state  <= eng_idle;
            end else begin
              rx_cnt <= rx_cnt + 3'd1;
            end
          end
        end
        default: begin
          state <= eng_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Data shifters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == eng_idle && req.start) begin
      out_sh <= req.out_data;
    end else if (state == eng_tx && sck_fall) begin
      out_sh <= {out_sh[shift_out_w-2:0], 1'b0};
    end
    // Received bits enter at the LSB, MSB first
    if (state == eng_rx && sck_fall) begin
      rx_sh <= {rx_sh[6:0], flash_io1};
    end
  end

endmodule

`default_nettype wire

//--- src/boot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module boot_sequencer import flash_boot_pkg::*; #(
  parameter int          reset_wait = 400,
  parameter flash_addr_t read_addr  = 24'h100000,
  parameter int          boot_words = 16,
  parameter int          rom_addr_w = 5
) (
  input  wire                    CLK,
  input  wire                    rst_n,
  input  wire shift_rsp_t        rsp,
  output shift_req_t             req,
  output logic                   flash_ssb,
  output logic                   rom_wr_load,
  output logic [rom_addr_w-1:0]  rom_wr_addr,
  output rom_word_u              rom_wr_data,
  output logic                   boot_done
);

  localparam logic [2:0] st_rst1   = 3'd0;
  localparam logic [2:0] st_rst2   = 3'd1;
  localparam logic [2:0] st_settle = 3'd2;
  localparam logic [2:0] st_cmd    = 3'd3;
  localparam logic [2:0] st_addr   = 3'd4;
  localparam logic [2:0] st_byte   = 3'd5;
  localparam logic [2:0] st_write  = 3'd6;
  localparam logic [2:0] st_done   = 3'd7;

  localparam int settle_w = (reset_wait > 1) ? $clog2(reset_wait) : 1;
  localparam logic [settle_w-1:0]   last_settle = settle_w'(reset_wait - 1);
  localparam logic [rom_addr_w-1:0] last_word   = rom_addr_w'(boot_words - 1);

  logic [2:0]            state;
  logic                  sent;
  logic                  lo_next;
  logic [settle_w-1:0]   settle_cnt;
  logic [rom_addr_w-1:0] word_cnt;

  // Eight-bit command, left aligned in the shift data
  function automatic shift_req_t cmd_req(input logic [7:0] cmd);
    return '{start: 1'b1, out_bits: 5'd8,
             out_data: {cmd, {(shift_out_w - 8){1'b0}}}, rx: 1'b0};
  endfunction

  // One byte in, nothing out
  function automatic shift_req_t rx_req();
    return '{start: 1'b1, out_bits: 5'd0, out_data: '0, rx: 1'b1};
  endfunction

  ////////////////////////////////////////////////////////////
  // Boot FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state       <= st_rst1;
      sent        <= 1'b0;
      lo_next     <= 1'b0;
      settle_cnt  <= '0;
      word_cnt    <= '0;
      req         <= '0;
      flash_ssb   <= 1'b1;
      rom_wr_load <= 1'b0;
      boot_done   <= 1'b0;
    end else begin
      req.start   <= 1'b0;
      rom_wr_load <= 1'b0;
      case (state)
        st_rst1: begin
          // Select and send 66h, deselect when the engine is done
          if (!sent) begin
            flash_ssb <= 1'b0;
            req       <= cmd_req(cmd_reset_enable);
            sent      <= 1'b1;
          end else if (rsp.done) begin
            flash_ssb <= 1'b1;
            sent      <= 1'b0;
            state     <= st_rst2;
          end
        end
        st_rst2: begin
          if (!sent) begin
            flash_ssb <= 1'b0;
            req       <= cmd_req(cmd_reset_memory);
            sent      <= 1'b1;
          end else if (rsp.done) begin
            flash_ssb  <= 1'b1;
            sent       <= 1'b0;
            settle_cnt <= '0;
            state      <= st_settle;
          end
        end
        st_settle: begin
          // Read frame opens on the last count so SSB is high reset_wait cycles
          if (settle_cnt == last_settle) begin
            flash_ssb <= 1'b0;
            req       <= cmd_req(cmd_read);
            state     <= st_cmd;
          end else begin
            settle_cnt <= settle_cnt + 1'b1;
          end
        end
        st_cmd: begin
          // Address follows straight on, first data byte comes with it
          if (rsp.done) begin
            req   <= '{start: 1'b1, out_bits: 5'(shift_out_w),
                       out_data: read_addr, rx: 1'b1};
            state <= st_addr;
          end
        end
        st_addr: begin
          // This byte is hi of word 0
          if (rsp.done) begin
            req     <= rx_req();
            lo_next <= 1'b1;
            state   <= st_byte;
          end
        end
        st_byte: begin
          if (rsp.done) begin
            if (lo_next) begin
              lo_next <= 1'b0;
              state   <= st_write;
            end else begin
              req     <= rx_req();
              lo_next <= 1'b1;
            end
          end
        end
        st_write: begin
          rom_wr_load <= 1'b1;
          if (word_cnt == last_word) begin
            // Last word, close the read frame
            flash_ssb <= 1'b1;
            state     <= st_done;
          end else begin
            word_cnt <= word_cnt + 1'b1;
            req      <= rx_req();
            state    <= st_byte;
          end
        end
        st_done: begin
          boot_done <= 1'b1;
        end
        default: begin
          state <= st_rst1;
        end
      endcase
    end
  end

  // Word assembly and write address
  always_ff @(posedge CLK) begin
    if (rsp.done && (state == st_addr || (state == st_byte && !lo_next))) begin
      rom_wr_data.bytes.hi <= rsp.rx_byte;
    end
    if (rsp.done && state == st_byte && lo_next) begin
      rom_wr_data.bytes.lo <= rsp.rx_byte;
    end
    if (state == st_write) begin
      rom_wr_addr <= word_cnt;
    end
  end

endmodule

`default_nettype wire

//--- src/boot_rom.sv
`timescale 1ns/1ps
`default_nettype none

module boot_rom #(
  parameter int rom_addr_w = 5
) (
  input  wire                   CLK,
  input  wire                   wr_load,
  input  wire  [rom_addr_w-1:0] wr_addr,
  input  wire  [15:0]           wr_data,
  input  wire  [rom_addr_w-1:0] rd_addr,
  output logic [15:0]           rd_data
);

  logic [15:0] mem [2**rom_addr_w];

  // Write port filled by the loader, read port registered
  always_ff @(posedge CLK) begin
    if (wr_load) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- src/flash_boot_top.sv
`timescale 1ns/1ps
`default_nettype none

module flash_boot_top import flash_boot_pkg::*; #(
  parameter int          clk_div    = 8,
  parameter int          reset_wait = 400,
  parameter flash_addr_t read_addr  = 24'h100000,
  parameter int          boot_words = 16,
  parameter int          rom_addr_w = 5
) (
  input  wire                   CLK,
  input  wire                   rst_n,
  input  wire                   flash_io1,
  input  wire  [rom_addr_w-1:0] rom_rd_addr,
  output wire                   flash_sck,
  output wire                   flash_ssb,
  output wire                   flash_io0,
  output wire                   flash_wp_n,
  output wire                   flash_hold_n,
  output wire                   boot_done,
  output wire  [15:0]           rom_rd_data
);

  shift_req_t            shift_req;
  shift_rsp_t            shift_rsp;
  logic                  sck_en;
  logic                  sck_rise;
  logic                  sck_fall;
  logic                  rom_wr_load;
  logic [rom_addr_w-1:0] rom_wr_addr;
  rom_word_u             rom_wr_data;

  // Write protect and hold unused, keep inactive
  assign flash_wp_n   = 1'b1;
  assign flash_hold_n = 1'b1;

  flash_sck_gen #(.clk_div(clk_div)) u_sck_gen (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .sck_en   (sck_en),
    .sck      (flash_sck),
    .sck_rise (sck_rise),
    .sck_fall (sck_fall)
  );

  flash_shift_engine u_shift_engine (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .req       (shift_req),
    .sck_rise  (sck_rise),
    .sck_fall  (sck_fall),
    .flash_io1 (flash_io1),
    .rsp       (shift_rsp),
    .sck_en    (sck_en),
    .flash_io0 (flash_io0)
  );

  boot_sequencer #(
    .reset_wait (reset_wait),
    .read_addr  (read_addr),
    .boot_words (boot_words),
    .rom_addr_w (rom_addr_w)
  ) u_sequencer (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .rsp         (shift_rsp),
    .req         (shift_req),
    .flash_ssb   (flash_ssb),
    .rom_wr_load (rom_wr_load),
    .rom_wr_addr (rom_wr_addr),
    .rom_wr_data (rom_wr_data),
    .boot_done   (boot_done)
  );

  // ROM sees the assembled pair as one word
  boot_rom #(.rom_addr_w(rom_addr_w)) u_boot_rom (
    .CLK     (CLK),
    .wr_load (rom_wr_load),
    .wr_addr (rom_wr_addr),
    .wr_data (rom_wr_data.word),
    .rd_addr (rom_rd_addr),
    .rd_data (rom_rd_data)
  );

endmodule

`default_nettype wire

//--- tb/flash_boot_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module flash_boot_asserts (
  input wire CLK,
  input wire rst_n,
  input wire sck,
  input wire ssb,
  input wire sck_rise,
  input wire sck_fall
);

  // SCK holds still between frames
  property sck_stable_deselected;
    @(posedge CLK) disable iff (!rst_n)
      (ssb && $past(ssb)) |-> $stable(sck);
  endproperty

  // Idle level is low
  property sck_low_deselected;
    @(posedge CLK) disable iff (!rst_n)
      (ssb && $past(ssb)) |-> !sck;
  endproperty

  // One edge per strobe cycle
  property strobes_exclusive;
    @(posedge CLK) disable iff (!rst_n)
      !(sck_rise && sck_fall);
  endproperty

  a_sck_stable: assert property (sck_stable_deselected)
    else $error("SCK toggled while SSB high");
  a_sck_low: assert property (sck_low_deselected)
    else $error("SCK high while SSB high");
  a_strobes: assert property (strobes_exclusive)
    else $error("sck_rise and sck_fall high together");

endmodule

bind flash_boot_top flash_boot_asserts u_asserts (
  .CLK      (CLK),
  .rst_n    (rst_n),
  .sck      (flash_sck),
  .ssb      (flash_ssb),
  .sck_rise (sck_rise),
  .sck_fall (sck_fall)
);

`default_nettype wire

//--- tb/tb_flash_boot.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flash_boot;

  ////////////////////////////////////////////////////////////
  // Test setup
  ////////////////////////////////////////////////////////////

  localparam int          clk_div     = 2;
  localparam int          reset_wait  = 20;
  localparam logic [23:0] read_addr   = 24'h100000;
  localparam int          boot_words  = 16;
  localparam int          rom_addr_w  = 5;
  localparam int          image_bytes = 2 * boot_words;
  // Flash bits times SCK period, settle wait, readback and margin
  localparam int timeout_cycles = (2 * 8 + 32 + image_bytes * 8) * 2 * clk_div
                                  + reset_wait + boot_words * 40 + 500;
  localparam logic [31:0] lfsr_seed = 32'h33a0_c96f;

  logic                  CLK;
  logic                  rst_n;
  logic                  flash_io1;
  logic [rom_addr_w-1:0] rom_rd_addr;
  wire                   flash_sck;
  wire                   flash_ssb;
  wire                   flash_io0;
  wire                   flash_wp_n;
  wire                   flash_hold_n;
  wire                   boot_done;
  wire  [15:0]           rom_rd_data;

  // Flash contents, byte 0 goes out first
  logic [7:0]  image [image_bytes];
  int          errors;
  int          checks;
  int          cycle_cnt;

  // Flash model state
  logic        sck_prev;
  logic        ssb_prev;
  int          frames_ended;
  int          frame_rises;
  int          data_bits;
  int          gap_cycles;
  logic [31:0] head_bits;
  int          frame_len [3];
  logic [31:0] frame_head [3];

  flash_boot_top #(
    .clk_div    (clk_div),
    .reset_wait (reset_wait),
    .read_addr  (read_addr),
    .boot_words (boot_words),
    .rom_addr_w (rom_addr_w)
  ) DUT (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .flash_io1    (flash_io1),
    .rom_rd_addr  (rom_rd_addr),
    .flash_sck    (flash_sck),
    .flash_ssb    (flash_ssb),
    .flash_io0    (flash_io0),
    .flash_wp_n   (flash_wp_n),
    .flash_hold_n (flash_hold_n),
    .boot_done    (boot_done),
    .rom_rd_data  (rom_rd_data)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Word i is the big-endian pair of image bytes 2i and 2i+1
  function automatic logic [15:0] expected_word(input int idx);
    return {image[2 * idx], image[2 * idx + 1]};
  endfunction

  task automatic fill_image();
    logic [31:0] s;
    int          b;
    int          k;
    s = lfsr_seed;
    for (b = 0; b < image_bytes; b++) begin
      // One LFSR step per image bit
      for (k = 0; k < 8; k++) begin
        s = lfsr_step(s);
        image[b] = {image[b][6:0], s[0]};
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  // Registered read port, data one cycle after the address
  task automatic read_rom();
    int i;
    for (i = 0; i < boot_words; i++) begin
      @(posedge CLK);
      rom_rd_addr <= rom_addr_w'(i);
      @(posedge CLK);
      @(negedge CLK);
      check_value($sformatf("rom word %0d", i), expected_word(i), rom_rd_data);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Flash chip model, sampled on CLK
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (!rst_n) begin
      sck_prev     = 1'b0;
      ssb_prev     = 1'b1;
      frames_ended = 0;
      frame_rises  = 0;
      data_bits    = 0;
      gap_cycles   = 0;
      head_bits    = '0;
    end else begin
      // Frame opens on SSB fall
      if (ssb_prev && !flash_ssb) begin
        frame_rises = 0;
        head_bits   = '0;
      end
      // SCK rise inside a frame, IO0 is stable here
      if (!flash_ssb && flash_sck && !sck_prev) begin
        if (frame_rises < 32) begin
          head_bits = {head_bits[30:0], flash_io0};
        end
        frame_rises++;
        // Read data starts after command and address, next bit after each rise
        if (frames_ended == 2 && frame_rises >= 32 && data_bits < image_bytes * 8) begin
          flash_io1 <= image[data_bits / 8][7 - data_bits % 8];
          data_bits++;
        end
      end
      // Frame closes on SSB rise
      if (!ssb_prev && flash_ssb) begin
        if (frames_ended < 3) begin
          frame_len[frames_ended]  = frame_rises;
          frame_head[frames_ended] = head_bits;
        end
        frames_ended++;
      end
      // Deselected time between reset frames and read frame
      if (flash_ssb && frames_ended == 2) begin
        gap_cycles++;
      end
      if (flash_ssb && ssb_prev && flash_sck !== sck_prev) begin
        errors++;
        $display("SCK toggled while the flash was deselected at %0t", $time);
      end
      if (flash_ssb && ssb_prev && flash_sck !== 1'b0) begin
        errors++;
        $display("SCK was high while the flash was deselected at %0t", $time);
      end
      if (DUT.sck_rise && DUT.sck_fall) begin
        errors++;
        $display("SCK rise and fall strobes were high together at %0t", $time);
      end
      if (boot_done && flash_sck !== 1'b0) begin
        errors++;
        $display("SCK was not low after boot_done at %0t", $time);
      end
      sck_prev = flash_sck;
      ssb_prev = flash_ssb;
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    errors      = 0;
    checks      = 0;
    rst_n       = 1'b0;
    flash_io1   = 1'b0;
    rom_rd_addr = '0;
    fill_image();
    repeat (4) @(posedge CLK);
    rst_n <= 1'b1;
    // Loader runs on its own until boot_done
    while (boot_done !== 1'b1) begin
      @(posedge CLK);
    end
    checks++;
    if (flash_ssb !== 1'b1) begin
      errors++;
      $display("Flash was still selected when boot_done rose");
    end
    read_rom();
    // WP and HOLD stay inactive
    check_value("write protect level", 1, flash_wp_n);
    check_value("hold level", 1, flash_hold_n);
    // Frame log from the flash model
    check_value("frame count", 3, frames_ended);
    check_value("reset enable length", 8, frame_len[0]);
    check_value("reset enable command", 32'h66, frame_head[0][7:0]);
    check_value("reset memory length", 8, frame_len[1]);
    check_value("reset memory command", 32'h99, frame_head[1][7:0]);
    check_value("settle gap", reset_wait, gap_cycles);
    check_value("read header", {8'h03, read_addr}, frame_head[2]);
    // First data bit rides on the 32nd rise, last byte ends on a fall
    check_value("read frame rises", 32 + image_bytes * 8 - 1, frame_len[2]);
    check_value("read data bits", image_bytes * 8, data_bits);
    finish_run();
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    errors++;
    $display("Timeout, boot and readback did not finish within %0d cycles", timeout_cycles);
    finish_run();
  end

endmodule

`default_nettype wire

//--- tb.f
src/flash_boot_pkg.sv
src/flash_sck_gen.sv
src/flash_shift_engine.sv
src/boot_sequencer.sv
src/boot_rom.sv
src/flash_boot_top.sv
tb/flash_boot_asserts.sv
tb/tb_flash_boot.sv
